//--- design/core_wb_pkg.sv
// Shared widths, opcodes and pipeline structs, imported by every module of the EX/WB slice

package core_wb_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Widths

  // Data path width of the core
  localparam int unsigned WORD_W    = 32;
  // Register index width, fixed to a 32-entry file
  localparam int unsigned RF_ADDR_W = 5;

  // One data word, used for operands, results and bus data
  typedef logic [WORD_W-1:0]    word_t;
  // Register file index
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  //////////////////////////////////////////////////////////////////////////
  // Opcodes and states

  // Operation selector carried on the issue port
  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_load = 3'd5
  } alu_op_e;

  // Execute stage occupancy
  typedef enum logic [1:0] {
    ex_idle     = 2'd0,
    ex_busy     = 2'd1,
    ex_wait_gnt = 2'd2
  } ex_state_e;

  //////////////////////////////////////////////////////////////////////////
  // Pipeline structs

  // One issued operation, about 73 bits
  typedef struct packed {
    alu_op_e  opcode;
    word_t    op_a;
    word_t    op_b;
    logic     rf_we;
    rf_addr_t rf_waddr;
  } issue_op_t;

  // EX to WB pipeline register
  typedef struct packed {
    logic     instr_valid;
    logic     lsu_en;
    logic     rf_we;
    rf_addr_t rf_waddr;
    word_t    rf_wdata;
  } ex_wb_pipe_t;

  // Reduced controller, acts on WB only
  typedef struct packed {
    logic halt_wb;
    logic kill_wb;
  } ctrl_fsm_t;

endpackage

//--- design/ex_stage.sv
// Execute stage: accepts issued operations, runs the ALU or starts a load, fills the EX/WB register

module ex_stage (
  input  logic                     clk,
  input  logic                     arst_n_i,

  // Issue port
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  core_wb_pkg::issue_op_t   issue_op_i,

  // Write-back readiness
  input  logic                     wb_ready_i,

  // Load request towards the load unit
  output logic                     lsu_req_o,
  output core_wb_pkg::word_t       lsu_addr_o,
  input  logic                     lsu_gnt_i,

  // EX/WB pipeline register
  output core_wb_pkg::ex_wb_pipe_t ex_wb_pipe_o
);

  import core_wb_pkg::*;

  ex_state_e   state_q;
  ex_state_e   state_d;
  issue_op_t   op_q;
  logic        accept_en_q;
  logic        issue_fire;
  logic        ex_leave;
  word_t       alu_result;
  ex_wb_pipe_t ex_wb_pipe_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes

  // Entry leaves EX: ALU op once WB is ready, load on its grant
  assign ex_leave = ((state_q == ex_busy) && wb_ready_i) ||
                    ((state_q == ex_wait_gnt) && lsu_gnt_i);

  // Port opens one cycle after reset, then accepts when EX empties
  assign issue_ready_o = accept_en_q && ((state_q == ex_idle) || ex_leave);
  assign issue_fire    = issue_valid_i && issue_ready_o;

  // Request held for the whole wait, address comes from the held operands
  assign lsu_req_o  = (state_q == ex_wait_gnt);
  assign lsu_addr_o = op_q.op_a + op_q.op_b;

  ////////////////////////////////////////////////////////////////////////////
  // ALU

  always_comb begin
    case (op_q.opcode)
      op_add:  alu_result = op_q.op_a + op_q.op_b;
      op_sub:  alu_result = op_q.op_a - op_q.op_b;
      op_and:  alu_result = op_q.op_a & op_q.op_b;
      op_or:   alu_result = op_q.op_a | op_q.op_b;
      op_xor:  alu_result = op_q.op_a ^ op_q.op_b;
      // Load carries its address, WB replaces it with bus data
      default: alu_result = lsu_addr_o;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State

  always_comb begin
    state_d = state_q;
    // Current entry gone, or never there
    if ((state_q == ex_idle) || ex_leave) begin
      if (issue_fire) begin
        state_d = (issue_op_i.opcode == op_load) ? ex_wait_gnt : ex_busy;
      end else begin
        state_d = ex_idle;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= ex_idle;
      accept_en_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      accept_en_q <= 1'b1;
    end
  end

  // Operand holding register
  always_ff @(posedge clk) begin
    if (issue_fire) begin
      op_q <= issue_op_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_wb_pipe_q.instr_valid <= 1'b0;
      ex_wb_pipe_q.lsu_en      <= 1'b0;
      ex_wb_pipe_q.rf_we       <= 1'b0;
    end else if (ex_leave) begin
      ex_wb_pipe_q.instr_valid <= 1'b1;
      ex_wb_pipe_q.lsu_en      <= (op_q.opcode == op_load);
      ex_wb_pipe_q.rf_we       <= op_q.rf_we;
      ex_wb_pipe_q.rf_waddr    <= op_q.rf_waddr;
      ex_wb_pipe_q.rf_wdata    <= alu_result;
    end else if (wb_ready_i) begin
      // WB retires or drops its entry and nothing follows
      ex_wb_pipe_q.instr_valid <= 1'b0;
    end
  end

  assign ex_wb_pipe_o = ex_wb_pipe_q;

endmodule

//--- design/load_unit.sv
// Load unit: drives the data bus for loads from EX and tracks the single outstanding response for WB

module load_unit (
  input  logic               clk,
  input  logic               arst_n_i,

  // Request from EX
  input  logic               lsu_req_i,
  input  core_wb_pkg::word_t lsu_addr_i,
  output logic               lsu_gnt_o,

  // Data bus
  output logic               data_req_o,
  output core_wb_pkg::word_t data_addr_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  core_wb_pkg::word_t data_rdata_i,

  // Response towards WB
  output logic               lsu_valid_o,
  output core_wb_pkg::word_t lsu_rdata_o,
  output logic               lsu_ready_o,

  // WB handshake back
  input  logic               wb_lsu_valid_i,
  input  logic               wb_lsu_ready_i
);

  logic outstanding_q;
  logic resp_done;

  ////////////////////////////////////////////////////////////////////////////
  // Request side

  // One load in flight at most, a new request waits for the response
  assign data_req_o  = lsu_req_i && !outstanding_q;

  // EX holds its operands, so the address stays put until the grant
  assign data_addr_o = lsu_addr_i;

  // Grant only counts for a request actually on the bus
  assign lsu_gnt_o   = data_req_o && data_gnt_i;

  ////////////////////////////////////////////////////////////////////////////
  // Response side

  // Response consumed when WB takes it
  assign resp_done = data_rvalid_i && wb_lsu_ready_i;

  // Outstanding flag
  // set by the grant, cleared by the response
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (lsu_gnt_o) begin
      outstanding_q <= 1'b1;
    end else if (resp_done) begin
      outstanding_q <= 1'b0;
    end
  end

  // Valid only for a response we expect and WB holds the load
  assign lsu_valid_o = data_rvalid_i && outstanding_q && wb_lsu_valid_i;

  // Read data goes straight to the WB mux
  assign lsu_rdata_o = data_rdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // Bus readiness

  // WB may advance with nothing pending, or on the cycle the response lands
  assign lsu_ready_o = !outstanding_q || resp_done;

endmodule

//--- design/wb_stage.sv
// Write-back stage: picks ALU or load data, drives the register file write and the stage handshake

module wb_stage (
  // EX/WB pipeline
  input  core_wb_pkg::ex_wb_pipe_t ex_wb_pipe_i,

  // Controller
  input  core_wb_pkg::ctrl_fsm_t   ctrl_fsm_i,

  // Load data
  input  core_wb_pkg::word_t       lsu_rdata_i,

  // Load unit handshake
  input  logic                     lsu_valid_i,
  input  logic                     lsu_ready_i,
  output logic                     lsu_valid_o,
  output logic                     lsu_ready_o,

  // Register file write port
  output logic                     rf_we_wb_o,
  output core_wb_pkg::rf_addr_t    rf_waddr_wb_o,
  output core_wb_pkg::word_t       rf_wdata_wb_o,

  // Stage handshake
  output logic                     wb_ready_o,
  output logic                     wb_valid_o
);

  logic instr_valid;
  logic result_valid;

  // Entry counts only while not halted or killed
  assign instr_valid = ex_wb_pipe_i.instr_valid && !ctrl_fsm_i.kill_wb &&
                       !ctrl_fsm_i.halt_wb;

  // ALU result ready at once, load result with its response
  assign result_valid = !ex_wb_pipe_i.lsu_en || lsu_valid_i;

  ////////////////////////////////////////////////////////////////////////////
  // Register file write

  // Load writes only on rvalid, so stale bus data never lands
  assign rf_we_wb_o    = ex_wb_pipe_i.rf_we && instr_valid && result_valid;
  assign rf_waddr_wb_o = ex_wb_pipe_i.rf_waddr;
  assign rf_wdata_wb_o = ex_wb_pipe_i.lsu_en ? lsu_rdata_i : ex_wb_pipe_i.rf_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // Load unit handshake

  // Ignores kill and halt, the controller never touches a granted load
  assign lsu_valid_o = ex_wb_pipe_i.lsu_en && ex_wb_pipe_i.instr_valid;
  // Last stage, nothing downstream to wait for
  assign lsu_ready_o = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Stage handshake

  // Follows bus readiness, halt holds the entry in place
  assign wb_ready_o = lsu_ready_i && !ctrl_fsm_i.halt_wb;
  assign wb_valid_o = result_valid && instr_valid;

endmodule

//--- design/register_file.sv
// Register file: RF_DEPTH words with x0 fixed at zero, one synchronous write and one combinational read

module register_file #(
  parameter int unsigned RF_DEPTH = 32
) (
  input  logic                  clk,
  input  logic                  arst_n_i,

  // Write port
  input  logic                  we_i,
  input  core_wb_pkg::rf_addr_t waddr_i,
  input  core_wb_pkg::word_t    wdata_i,

  // Read port
  input  core_wb_pkg::rf_addr_t raddr_i,
  output core_wb_pkg::word_t    rdata_o
);

  import core_wb_pkg::*;

  word_t regs_q [RF_DEPTH];
  logic  wr_ok;

  // x0 and indices past the depth are never written
  assign wr_ok = we_i && (waddr_i != '0) && (int'(waddr_i) < RF_DEPTH);

  ////////////////////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < RF_DEPTH; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_ok) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read

  // Out of range reads as zero, like x0
  always_comb begin
    if ((raddr_i == '0) || (int'(raddr_i) >= RF_DEPTH)) begin
      rdata_o = '0;
    end else begin
      rdata_o = regs_q[raddr_i];
    end
  end

endmodule

//--- design/core_wb_top.sv
// Top level of the EX/WB slice: wires the execute stage, load unit, write-back stage and register file

module core_wb_top #(
  parameter int unsigned RF_DEPTH = 32
) (
  input  logic                   clk,
  input  logic                   arst_n_i,

  // Issue port
  input  logic                   issue_valid_i,
  output logic                   issue_ready_o,
  input  core_wb_pkg::issue_op_t issue_op_i,

  // Controller
  input  core_wb_pkg::ctrl_fsm_t ctrl_i,

  // Data bus
  output logic                   data_req_o,
  output core_wb_pkg::word_t     data_addr_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  core_wb_pkg::word_t     data_rdata_i,

  // Register observation port
  input  core_wb_pkg::rf_addr_t  rf_raddr_i,
  output core_wb_pkg::word_t     rf_rdata_o,

  // Retirement strobe
  output logic                   wb_valid_o
);

  import core_wb_pkg::*;

  // EX to WB
  ex_wb_pipe_t ex_wb_pipe;
  logic        wb_ready;

  // EX to load unit
  logic        lsu_req;
  word_t       lsu_addr;
  logic        lsu_gnt;

  // Load unit and WB
  logic        lsu_valid;
  word_t       lsu_rdata;
  logic        lsu_ready;
  logic        wb_lsu_valid;
  logic        wb_lsu_ready;

  // WB to register file
  logic        rf_we;
  rf_addr_t    rf_waddr;
  word_t       rf_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // Input side

  ex_stage i_ex_stage (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_op_i    (issue_op_i),
    .wb_ready_i    (wb_ready),
    .lsu_req_o     (lsu_req),
    .lsu_addr_o    (lsu_addr),
    .lsu_gnt_i     (lsu_gnt),
    .ex_wb_pipe_o  (ex_wb_pipe)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Load path

  load_unit i_load_unit (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .lsu_req_i      (lsu_req),
    .lsu_addr_i     (lsu_addr),
    .lsu_gnt_o      (lsu_gnt),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .lsu_valid_o    (lsu_valid),
    .lsu_rdata_o    (lsu_rdata),
    .lsu_ready_o    (lsu_ready),
    .wb_lsu_valid_i (wb_lsu_valid),
    .wb_lsu_ready_i (wb_lsu_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output side

  wb_stage i_wb_stage (
    .ex_wb_pipe_i  (ex_wb_pipe),
    .ctrl_fsm_i    (ctrl_i),
    .lsu_rdata_i   (lsu_rdata),
    .lsu_valid_i   (lsu_valid),
    .lsu_ready_i   (lsu_ready),
    .lsu_valid_o   (wb_lsu_valid),
    .lsu_ready_o   (wb_lsu_ready),
    .rf_we_wb_o    (rf_we),
    .rf_waddr_wb_o (rf_waddr),
    .rf_wdata_wb_o (rf_wdata),
    .wb_ready_o    (wb_ready),
    .wb_valid_o    (wb_valid_o)
  );

  register_file #(
    .RF_DEPTH (RF_DEPTH)
  ) i_register_file (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .raddr_i  (rf_raddr_i),
    .rdata_o  (rf_rdata_o)
  );

endmodule

//--- bench/core_wb_checker.sv
// Concurrent assertions on the EX/WB slice, attached to the top level by the bind below

module core_wb_checker (
  input logic                     clk,
  input logic                     arst_n_i,
  input logic                     issue_ready_i,
  input core_wb_pkg::ctrl_fsm_t   ctrl_i,
  input logic                     data_req_i,
  input core_wb_pkg::word_t       data_addr_i,
  input logic                     data_gnt_i,
  input logic                     data_rvalid_i,
  input logic                     wb_valid_i,
  input logic                     rf_we_i,
  input logic                     wb_ready_i,
  input core_wb_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input core_wb_pkg::ex_state_e   ex_state_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import core_wb_pkg::*;

  // Failed assertion count, read by the testbench at the end
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Reset

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n_i |-> (!data_req_i && !issue_ready_i && !wb_valid_i && !rf_we_i)
  ) else begin
    fail_cnt++;
    $error("Bus request, issue ready, write or retirement active during reset");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write-back

  // Load data lands only together with its response
  a_load_write_rvalid: assert property (@(posedge clk) disable iff (!arst_n_i)
    (rf_we_i && ex_wb_pipe_i.lsu_en) |-> data_rvalid_i
  ) else begin
    fail_cnt++;
    $error("Register write for a load without data_rvalid_i");
  end

  a_halt_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
    ctrl_i.halt_wb |-> !rf_we_i
  ) else begin
    fail_cnt++;
    $error("Register write while WB is halted");
  end

  // Controller never kills a load already in WB
  a_kill_not_load: assert property (@(posedge clk) disable iff (!arst_n_i)
    ctrl_i.kill_wb |-> !(ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.lsu_en)
  ) else begin
    fail_cnt++;
    $error("Kill raised while a load sits in WB");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes

  a_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    (data_req_i && !data_gnt_i) |=> (data_req_i && $stable(data_addr_i))
  ) else begin
    fail_cnt++;
    $error("Data request dropped or address changed before the grant");
  end

  // EX full and WB stalled leaves no room for a new operation
  a_issue_blocked: assert property (@(posedge clk) disable iff (!arst_n_i)
    ((ex_state_i != ex_idle) && !wb_ready_i) |-> !issue_ready_i
  ) else begin
    fail_cnt++;
    $error("Issue port ready while EX is full and WB is not ready");
  end

endmodule

bind core_wb_top core_wb_checker i_core_wb_checker (
  .clk           (clk),
  .arst_n_i      (arst_n_i),
  .issue_ready_i (issue_ready_o),
  .ctrl_i        (ctrl_i),
  .data_req_i    (data_req_o),
  .data_addr_i   (data_addr_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .wb_valid_i    (wb_valid_o),
  .rf_we_i       (rf_we),
  .wb_ready_i    (wb_ready),
  .ex_wb_pipe_i  (ex_wb_pipe),
  .ex_state_i    (i_ex_stage.state_q)
);

//--- bench/core_wb_tb.sv
// Testbench for the EX/WB slice: drives issue and controller, models data memory, reads registers

module core_wb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import core_wb_pkg::*;

  localparam int unsigned RF_DEPTH   = 32;
  // ALU 10, loads 6, kill 1, halt 2, x0 and rf_we low 3, mixed 20
  localparam int unsigned N_OPS      = 42;
  localparam int unsigned MAX_CYCLES = 40 * N_OPS + 200;
  localparam word_t       MEM_XOR    = 32'hA5A5_0000;

  logic      clk;
  logic      arst_n_i;
  logic      issue_valid_i;
  logic      issue_ready_o;
  issue_op_t issue_op_i;
  ctrl_fsm_t ctrl_i;
  logic      data_req_o;
  word_t     data_addr_o;
  logic      data_gnt_i;
  logic      data_rvalid_i;
  word_t     data_rdata_i;
  rf_addr_t  rf_raddr_i;
  word_t     rf_rdata_o;
  logic      wb_valid_o;

  integer      seed          = 55123;
  word_t       exp_rf [RF_DEPTH];
  int unsigned expected_cnt  = 0;
  int unsigned retired_cnt   = 0;
  int unsigned readback_errs = 0;
  int unsigned cycle_cnt     = 0;

  // Memory model state
  int unsigned gnt_delay     = 0;
  int unsigned resp_delay    = 0;
  logic        resp_pending  = 1'b0;
  word_t       resp_addr     = '0;

  core_wb_top #(
    .RF_DEPTH (RF_DEPTH)
  ) i_core_wb_top (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_op_i    (issue_op_i),
    .ctrl_i        (ctrl_i),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rf_raddr_i    (rf_raddr_i),
    .rf_rdata_o    (rf_rdata_o),
    .wb_valid_o    (wb_valid_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic int unsigned rand_range(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic word_t rand_word();
    return word_t'($random(seed));
  endfunction

  function automatic alu_op_e rand_alu_op();
    int unsigned pick;
    pick = rand_range(5);
    return alu_op_e'(pick[2:0]);
  endfunction

  // Result rule per opcode, loads read address XOR pattern
  function automatic word_t expected_result(alu_op_e op, word_t a, word_t b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      default: return (a + b) ^ MEM_XOR;
    endcase
  endfunction

  // Starts on a falling edge, returns on the falling edge after the transfer
  task automatic issue_op(alu_op_e op, word_t a, word_t b, logic we, rf_addr_t rd,
                          logic retires);
    issue_valid_i       = 1'b1;
    issue_op_i.opcode   = op;
    issue_op_i.op_a     = a;
    issue_op_i.op_b     = b;
    issue_op_i.rf_we    = we;
    issue_op_i.rf_waddr = rd;
    #1;
    while (!issue_ready_o) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    issue_valid_i = 1'b0;
    if (retires) begin
      expected_cnt++;
      if (we && (rd != '0)) begin
        exp_rf[rd] = expected_result(op, a, b);
      end
    end
  endtask

  // Every counted operation has left WB
  task automatic wait_retired();
    while (retired_cnt < expected_cnt) begin
      @(negedge clk);
    end
  endtask

  task automatic check_reg(rf_addr_t idx, word_t exp);
    rf_raddr_i = idx;
    #1;
    if (rf_rdata_o !== exp) begin
      readback_errs++;
      $display("Fail rf_rdata_o x%0d: expected %h, got %h", idx, exp, rf_rdata_o);
    end
    @(negedge clk);
  endtask

  task automatic check_all_regs();
    for (int unsigned i = 0; i < RF_DEPTH; i++) begin
      check_reg(rf_addr_t'(i), exp_rf[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors and memory

  always @(posedge clk) begin
    if (arst_n_i && wb_valid_o) begin
      retired_cnt <= retired_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: test did not end within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // Random grant delay, response at least one cycle after the grant
  always @(negedge clk) begin
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = 32'hDEAD_BEEF;
    if (resp_pending) begin
      if (resp_delay == 0) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = resp_addr ^ MEM_XOR;
        resp_pending  = 1'b0;
      end else begin
        resp_delay--;
      end
    end
    if (data_req_o) begin
      if (gnt_delay == 0) begin
        data_gnt_i   = 1'b1;
        resp_addr    = data_addr_o;
        resp_pending = 1'b1;
        resp_delay   = rand_range(4);
        gnt_delay    = rand_range(4);
      end else begin
        gnt_delay--;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    rf_addr_t    rd;
    alu_op_e     op;
    int unsigned assert_errs;
    arst_n_i      = 1'b0;
    issue_valid_i = 1'b0;
    issue_op_i    = '0;
    ctrl_i        = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    rf_raddr_i    = '0;
    for (int unsigned i = 0; i < RF_DEPTH; i++) begin
      exp_rf[i] = '0;
    end
    repeat (8) @(negedge clk);
    arst_n_i = 1'b1;
    check_all_regs();

    // Back to back ALU operations
    for (int unsigned i = 1; i <= 10; i++) begin
      issue_op(rand_alu_op(), rand_word(), rand_word(), 1'b1, rf_addr_t'(i), 1'b1);
    end
    for (int unsigned i = 11; i <= 16; i++) begin
      issue_op(op_load, rand_word(), rand_word(), 1'b1, rf_addr_t'(i), 1'b1);
    end
    wait_retired();
    for (int unsigned i = 1; i <= 16; i++) begin
      check_reg(rf_addr_t'(i), exp_rf[i]);
    end

    // Kill while the entry sits in WB
    issue_op(op_xor, 32'h1234_5678, 32'h0F0F_0F0F, 1'b1, 5'd17, 1'b0);
    @(negedge clk);
    ctrl_i.kill_wb = 1'b1;
    @(negedge clk);
    ctrl_i.kill_wb = 1'b0;
    check_reg(5'd17, '0);

    // Halt holding the entry in EX, then in WB
    ctrl_i.halt_wb = 1'b1;
    issue_op(op_add, rand_word(), rand_word(), 1'b1, 5'd18, 1'b1);
    repeat (4) @(negedge clk);
    check_reg(5'd18, '0);
    ctrl_i.halt_wb = 1'b0;
    wait_retired();
    check_reg(5'd18, exp_rf[18]);
    issue_op(op_sub, rand_word(), rand_word(), 1'b1, 5'd19, 1'b1);
    @(negedge clk);
    ctrl_i.halt_wb = 1'b1;
    repeat (4) @(negedge clk);
    check_reg(5'd19, '0);
    ctrl_i.halt_wb = 1'b0;
    wait_retired();
    check_reg(5'd19, exp_rf[19]);

    // x0 and operations without write enable
    issue_op(op_or, rand_word(), rand_word(), 1'b1, 5'd0, 1'b1);
    issue_op(op_add, rand_word(), rand_word(), 1'b0, 5'd20, 1'b1);
    issue_op(op_load, rand_word(), rand_word(), 1'b0, 5'd21, 1'b1);
    wait_retired();
    check_reg(5'd0, '0);
    check_reg(5'd20, exp_rf[20]);
    check_reg(5'd21, exp_rf[21]);

    // Mixed loads and ALU ops under random bus delays
    for (int unsigned i = 0; i < 20; i++) begin
      rd = rf_addr_t'(22 + rand_range(10));
      op = (rand_range(2) == 0) ? op_load : rand_alu_op();
      issue_op(op, rand_word(), rand_word(), 1'b1, rd, 1'b1);
    end
    wait_retired();
    check_all_regs();
    if (retired_cnt != expected_cnt) begin
      readback_errs++;
      $display("Fail retired_cnt: expected %h, got %h", expected_cnt, retired_cnt);
    end

    assert_errs = i_core_wb_top.i_core_wb_checker.fail_cnt;
    $display("Errors: %0d readback, %0d assertion", readback_errs, assert_errs);
    if ((readback_errs == 0) && (assert_errs == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- core_wb_top.f
design/core_wb_pkg.sv
design/ex_stage.sv
design/load_unit.sv
design/wb_stage.sv
design/register_file.sv
design/core_wb_top.sv
bench/core_wb_checker.sv
bench/core_wb_tb.sv

//--- Makefile
# Verilator flow for the EX/WB slice: lint, simulate, clean

VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := core_wb_tb
FILELIST  := core_wb_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Testbench passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
